// ==== logic/corr_cfg_pkg.sv ====
`default_nettype none

package corr_cfg_pkg;

   //------------------------------------------------------------
   // Array sizes
   //------------------------------------------------------------
   localparam int N_ANT  = 4;                 // Antennas in the array
   localparam int N_PAIR = N_ANT*(N_ANT-1)/2; // Distinct baselines, 6
   localparam int N_VIS  = 2*N_PAIR + N_ANT;  // Cos, sin and ones words, 16

   //------------------------------------------------------------
   // Baseline table
   //------------------------------------------------------------
   // Entry p names the two antennas of baseline p
   // Order is (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
   localparam logic [1:0] PAIR_A [0:N_PAIR-1] = '{
      2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd2
   };
   localparam logic [1:0] PAIR_B [0:N_PAIR-1] = '{
      2'd1, 2'd2, 2'd3, 2'd2, 2'd3, 2'd3
   };

   //------------------------------------------------------------
   // Front end output record
   //------------------------------------------------------------
   // One strobe worth of antenna data after the fake Hilbert step
   typedef struct packed {
      logic             valid; // Sample present this cycle
      logic             last;  // Final sample of the block
      logic [N_ANT-1:0] re;    // Current one-bit samples
      logic [N_ANT-1:0] im;    // Previous samples, used as imaginary part
   } front_t;

endpackage

`default_nettype wire

// ==== logic/axil_pkg.sv ====
`default_nettype none

package axil_pkg;

   // Master to slave half of the AXI4-Lite bus
   typedef struct packed {
      logic        awvalid;
      logic [11:0] awaddr;
      logic        wvalid;
      logic [31:0] wdata;
      logic [3:0]  wstrb;   // Byte lane enables
      logic        bready;
      logic        arvalid;
      logic [11:0] araddr;
      logic        rready;
   } axil_req_t;

   // Slave to master half
   typedef struct packed {
      logic        awready;
      logic        wready;
      logic        bvalid;
      logic [1:0]  bresp;
      logic        arready;
      logic        rvalid;
      logic [31:0] rdata;
      logic [1:0]  rresp;
   } axil_rsp_t;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   //------------------------------------------------------------
   // Register map, byte addresses
   //------------------------------------------------------------
   localparam logic [11:0] ADDR_CTRL     = 12'h000; // Bit 0 enables acquisition
   localparam logic [11:0] ADDR_BLKSIZE  = 12'h004; // Block size minus one
   localparam logic [11:0] ADDR_STATUS   = 12'h008; // Completed blocks, read only
   localparam logic [11:0] ADDR_VIS_BASE = 12'h100; // Word k at base + 4k

endpackage

`default_nettype wire

// ==== logic/sample_front.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_front #(
   parameter int ACC_W = 16
) (
   input  wire logic                         clk_i,
   input  wire logic                         sw_d,
   input  wire logic [corr_cfg_pkg::N_ANT-1:0] sample_i,
   input  wire logic                         sample_valid_i,
   input  wire logic                         acq_enable_i,
   input  wire logic [ACC_W-1:0]             block_len_i, // Block size minus one
   output corr_cfg_pkg::front_t              front_o
);

   //------------------------------------------------------------
   // Sample qualification and block position
   //------------------------------------------------------------
   logic                          take;     // Strobe accepted this cycle
   logic                          at_end;   // Taken sample closes the block
   logic [ACC_W-1:0]              cnt_q;    // Samples taken so far in block
   logic [corr_cfg_pkg::N_ANT-1:0] prev_q;  // Last taken sample, per antenna
   corr_cfg_pkg::front_t          front_q;

   assign take   = sample_valid_i & acq_enable_i;
   assign at_end = (cnt_q == block_len_i);

   // Block counter and Hilbert history
   // Both restart whenever acquisition is switched off
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         cnt_q  <= '0;
         prev_q <= '0;
      end else if (!acq_enable_i) begin
         cnt_q  <= '0;
         prev_q <= '0;                        // First sample after enable sees im = 0
      end else if (take) begin
         cnt_q  <= at_end ? '0 : cnt_q + 1'b1; // Wrap at block end
         prev_q <= sample_i;                  // Carries across block boundaries
      end
   end

   //------------------------------------------------------------
   // Output register
   //------------------------------------------------------------
   // Imaginary part is the previous sample of the same antenna,
   // a quarter-period delay approximation for one-bit data
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         front_q <= '0;
      end else begin
         front_q.valid <= take;
         front_q.last  <= take & at_end;
         if (take) begin
            front_q.re <= sample_i;
            front_q.im <= prev_q;
         end
      end
   end

   assign front_o = front_q;

   // First sample after enable rises carries no history, else the
   // sine counts of a fresh run would pick up a stale sample
   a_first_im_zero: assert property (
      @(posedge clk_i) disable iff (sw_d)
      (front_o.valid && !$past(acq_enable_i, 2)) |-> (front_o.im == '0)
   );

endmodule

`default_nettype wire

// ==== logic/vis_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

module vis_accum #(
   parameter int ACC_W = 16
) (
   input  wire logic                 clk_i,
   input  wire logic                 sw_d,
   input  wire corr_cfg_pkg::front_t front_i,
   input  wire logic [3:0]           rd_index_i,
   output logic [ACC_W-1:0]          rd_data_o,
   output logic                      bank_swap_o
);

   localparam int N_ANT   = corr_cfg_pkg::N_ANT;
   localparam int N_PAIR  = corr_cfg_pkg::N_PAIR;
   localparam int N_VIS   = corr_cfg_pkg::N_VIS;
   localparam int SIN_OFS = N_PAIR;   // First sine word
   localparam int ONE_OFS = 2*N_PAIR; // First ones word

   //------------------------------------------------------------
   // Agreement bits for the current sample
   //------------------------------------------------------------
   logic [N_VIS-1:0] hit;              // One increment bit per word
   logic [ACC_W-1:0] sum    [N_VIS];   // Running count plus this sample
   logic [ACC_W-1:0] acc_q  [N_VIS];   // Accumulating bank
   logic [ACC_W-1:0] bank_q [N_VIS];   // Read bank, last completed block
   logic             swap_q;

   always_comb begin
      for (int p = 0; p < N_PAIR; p++) begin
         // Cosine term, both real parts agree (XNOR of one-bit signs)
         hit[p]         = front_i.re[corr_cfg_pkg::PAIR_A[p]] ~^
                          front_i.re[corr_cfg_pkg::PAIR_B[p]];
         // Sine term, real of A against imaginary of B
         hit[SIN_OFS+p] = front_i.re[corr_cfg_pkg::PAIR_A[p]] ~^
                          front_i.im[corr_cfg_pkg::PAIR_B[p]];
      end
      for (int a = 0; a < N_ANT; a++) begin
         hit[ONE_OFS+a] = front_i.re[a];  // Mean estimate, gains are unknown
      end
   end

   always_comb begin
      for (int k = 0; k < N_VIS; k++) begin
         sum[k] = acc_q[k] + {{(ACC_W-1){1'b0}}, hit[k]};
      end
   end

   //------------------------------------------------------------
   // Accumulate and swap
   //------------------------------------------------------------
   // The last sample of a block goes straight into the read bank
   // together with the running sums, so no sample is lost at a swap
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         for (int k = 0; k < N_VIS; k++) begin
            acc_q[k]  <= '0;
            bank_q[k] <= '0;                  // Software sees zeros before block one
         end
         swap_q <= 1'b0;
      end else begin
         swap_q <= front_i.valid & front_i.last;
         if (front_i.valid) begin
            for (int k = 0; k < N_VIS; k++) begin
               if (front_i.last) begin
                  bank_q[k] <= sum[k];        // Publish final sums
                  acc_q[k]  <= '0;            // Restart for next block
               end else begin
                  acc_q[k]  <= sum[k];
               end
            end
         end
      end
   end

   assign bank_swap_o = swap_q;                // One-cycle pulse after the last sample
   assign rd_data_o   = bank_q[rd_index_i];    // Same-cycle read mux

   // Read bank moves only together with the swap pulse,
   // so software never sees a block that was not announced
   a_bank_hold: assert property (
      @(posedge clk_i) disable iff (sw_d)
      (!bank_swap_o && $stable(rd_index_i)) |-> $stable(rd_data_o)
   );

endmodule

`default_nettype wire

// ==== logic/corr_bus_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module corr_bus_regs #(
   parameter int ACC_W = 16
) (
   input  wire logic                 clk_i,
   input  wire logic                 sw_d,
   input  wire axil_pkg::axil_req_t  axil_req_i,
   output axil_pkg::axil_rsp_t       axil_rsp_o,
   output logic                      acq_enable_o,
   output logic [ACC_W-1:0]          block_len_o,
   input  wire logic                 bank_swap_i,
   output logic [3:0]                rd_index_o,
   input  wire logic [ACC_W-1:0]     rd_data_i
);

   // Byte-lane merge of a write into the old register value
   function automatic logic [31:0] merge_strb(input logic [31:0] old_v,
                                              input logic [31:0] new_v,
                                              input logic [3:0]  strb);
      logic [31:0] mask;
      for (int b = 0; b < 4; b++) begin
         mask[8*b +: 8] = {8{strb[b]}};
      end
      return (old_v & ~mask) | (new_v & mask);
   endfunction

   //------------------------------------------------------------
   // Control registers and write channel
   //------------------------------------------------------------
   logic             enable_q;
   logic [ACC_W-1:0] blk_q;        // Block size minus one
   logic [31:0]      status_q;     // Completed blocks since reset
   logic             aw_take, bvalid_q;
   logic [1:0]       bresp_q;
   logic [31:0]      ctrl_new, blk_new;

   // Address and data must arrive together, one response in flight
   assign aw_take  = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
   assign ctrl_new = merge_strb({31'b0, enable_q}, axil_req_i.wdata, axil_req_i.wstrb);
   assign blk_new  = merge_strb(32'(blk_q), axil_req_i.wdata, axil_req_i.wstrb);

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         enable_q <= 1'b0;
         blk_q    <= '0;
         bvalid_q <= 1'b0;
      end else if (aw_take) begin
         bvalid_q <= 1'b1;
         if (axil_req_i.awaddr == axil_pkg::ADDR_CTRL) begin
            enable_q <= ctrl_new[0];
         end else if (axil_req_i.awaddr == axil_pkg::ADDR_BLKSIZE) begin
            blk_q    <= blk_new[ACC_W-1:0];
         end
      end else if (axil_req_i.bready) begin
         bvalid_q <= 1'b0;                   // Response taken
      end
   end

   // Anything outside the two writable words is refused
   always_ff @(posedge clk_i) begin
      if (aw_take) begin
         bresp_q <= (axil_req_i.awaddr == axil_pkg::ADDR_CTRL ||
                     axil_req_i.awaddr == axil_pkg::ADDR_BLKSIZE) ?
                    axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
      end
   end

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d)             status_q <= '0;
      else if (bank_swap_i) status_q <= status_q + 1'b1; // One per finished block
   end

   //------------------------------------------------------------
   // Read channel
   //------------------------------------------------------------
   logic        ar_take, rvalid_q, vis_hit, rd_err;
   logic [11:0] vis_off;        // Byte offset into the visibility window
   logic [31:0] rd_word, rdata_q;
   logic [1:0]  rresp_q;

   assign ar_take    = axil_req_i.arvalid & ~rvalid_q;
   assign vis_off    = axil_req_i.araddr - axil_pkg::ADDR_VIS_BASE;
   assign vis_hit    = (axil_req_i.araddr >= axil_pkg::ADDR_VIS_BASE) &&
                       (vis_off < 12'(4*corr_cfg_pkg::N_VIS)) &&
                       (axil_req_i.araddr[1:0] == 2'b00);
   assign rd_index_o = vis_off[5:2];     // Word index into the read bank

   always_comb begin
      rd_err  = 1'b0;
      rd_word = '0;
      if (vis_hit)                                         rd_word = 32'(rd_data_i);
      else if (axil_req_i.araddr == axil_pkg::ADDR_CTRL)    rd_word = {31'b0, enable_q};
      else if (axil_req_i.araddr == axil_pkg::ADDR_BLKSIZE) rd_word = 32'(blk_q);
      else if (axil_req_i.araddr == axil_pkg::ADDR_STATUS)  rd_word = status_q;
      else                                                 rd_err  = 1'b1; // Zero data
   end

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d)                    rvalid_q <= 1'b0;
      else if (ar_take)            rvalid_q <= 1'b1;
      else if (axil_req_i.rready)  rvalid_q <= 1'b0;
   end

   // Data is captured at acceptance and held while the master stalls
   always_ff @(posedge clk_i) begin
      if (ar_take) begin
         rdata_q <= rd_word;
         rresp_q <= rd_err ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
      end
   end

   always_comb begin
      axil_rsp_o.awready = aw_take;
      axil_rsp_o.wready  = aw_take;
      axil_rsp_o.bvalid  = bvalid_q;
      axil_rsp_o.bresp   = bresp_q;
      axil_rsp_o.arready = ar_take;
      axil_rsp_o.rvalid  = rvalid_q;
      axil_rsp_o.rdata   = rdata_q;
      axil_rsp_o.rresp   = rresp_q;
   end

   assign acq_enable_o = enable_q;
   assign block_len_o  = blk_q;

   // A stalled read beat must not move, even across a bank swap
   a_r_hold: assert property (
      @(posedge clk_i) disable iff (sw_d)
      (rvalid_q && !axil_req_i.rready) |=> (rvalid_q && $stable(rdata_q))
   );

endmodule

`default_nettype wire

// ==== logic/corr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module corr_top #(
   parameter int ACC_W = 16   // Accumulator and block size width
) (
   input  wire logic                         clk_i,
   input  wire logic                         sw_d,
   input  wire logic [corr_cfg_pkg::N_ANT-1:0] sample_i,
   input  wire logic                         sample_valid_i,
   input  wire axil_pkg::axil_req_t          axil_req_i,
   output axil_pkg::axil_rsp_t               axil_rsp_o
);

   //------------------------------------------------------------
   // Internal links
   //------------------------------------------------------------
   logic                 acq_enable;  // From CTRL bit 0
   logic [ACC_W-1:0]     block_len;   // Block size minus one
   corr_cfg_pkg::front_t front;       // Processed sample stream
   logic [ACC_W-1:0]     rd_data;     // Selected read-bank word
   logic                 bank_swap;   // Block completed
   logic [3:0]           rd_index;

   // Producer, qualified samples plus fake Hilbert imaginaries
   sample_front #(.ACC_W(ACC_W)) sample_front_i (
      .clk_i          (clk_i),
      .sw_d           (sw_d),
      .sample_i       (sample_i),
      .sample_valid_i (sample_valid_i),
      .acq_enable_i   (acq_enable),
      .block_len_i    (block_len),
      .front_o        (front)
   );

   // Double-banked correlator counts
   vis_accum #(.ACC_W(ACC_W)) vis_accum_i (
      .clk_i       (clk_i),
      .sw_d        (sw_d),
      .front_i     (front),
      .rd_index_i  (rd_index),
      .rd_data_o   (rd_data),
      .bank_swap_o (bank_swap)
   );

   // AXI4-Lite register block
   corr_bus_regs #(.ACC_W(ACC_W)) corr_bus_regs_i (
      .clk_i        (clk_i),
      .sw_d         (sw_d),
      .axil_req_i   (axil_req_i),
      .axil_rsp_o   (axil_rsp_o),
      .acq_enable_o (acq_enable),
      .block_len_o  (block_len),
      .bank_swap_i  (bank_swap),
      .rd_index_o   (rd_index),
      .rd_data_i    (rd_data)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

// Free-running clock for the testbench
module tb_clock #(
   parameter real PERIOD_NS = 8.0   // Full clock period
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;                               // Known level before first edge
      forever #(PERIOD_NS/2.0) clk_o = ~clk_o;    // Half period per toggle
   end

endmodule

`default_nettype wire

// ==== testbench/corr_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module corr_top_tb;

   localparam int ACC_W     = 16;
   localparam int N_VIS     = corr_cfg_pkg::N_VIS;
   localparam int N_PAIR    = corr_cfg_pkg::N_PAIR;
   localparam int N_ANT     = corr_cfg_pkg::N_ANT;
   localparam int MAX_BLK   = 40;   // Longest block any test drives
   localparam int N_BLOCK   = 8;    // Full and partial blocks over the run
   localparam int MAX_GAP   = 3;    // Idle cycles ahead of a strobe
   localparam int N_XFER    = 200;  // Bus transfers, reads and writes together
   localparam int MAX_STALL = 9;    // Longest rready hold-off
   localparam int LIMIT     = N_BLOCK*MAX_BLK*(MAX_GAP+1) + N_XFER*(MAX_STALL+6) + 500;

   logic                clk, sw_d, sample_valid;
   logic [N_ANT-1:0]    sample;
   axil_pkg::axil_req_t axil_req;
   axil_pkg::axil_rsp_t axil_rsp;
   logic [31:0]         lfsr;          // Random source state
   int                  n_checks, n_errors, cycles;

   // Reference model state
   logic [31:0]      m_acc  [N_VIS];   // Running counts
   logic [31:0]      m_bank [N_VIS];   // Last completed block
   logic [N_ANT-1:0] m_prev;           // Imaginary history
   int               m_cnt, m_len, m_status;
   logic             m_en;

   tb_clock #(.PERIOD_NS(8.0)) tb_clock_i (.clk_o(clk));

   corr_top #(.ACC_W(ACC_W)) corr_top_i (
      .clk_i          (clk),
      .sw_d           (sw_d),
      .sample_i       (sample),
      .sample_valid_i (sample_valid),
      .axil_req_i     (axil_req),
      .axil_rsp_o     (axil_rsp)
   );

   // Watchdog sized from the test lengths
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("Timeout, the run was still busy after %0d cycles", cycles);
         $display("Checks failed");
         $finish;
      end
   end

   //------------------------------------------------------------
   // Random bits and comparison
   //------------------------------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // Galois, 32-bit taps
   endfunction

   task automatic draw(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};   // One step per bit
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      end
   endtask

   task automatic test_done(input string name, input int e0);
      $display("Test %-16s finished with %0d errors", name, n_errors - e0);
   endtask

   //------------------------------------------------------------
   // AXI4-Lite master
   //------------------------------------------------------------
   task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      @(posedge clk);
      axil_req.awvalid <= 1'b1;
      axil_req.awaddr  <= addr;
      axil_req.wvalid  <= 1'b1;
      axil_req.wdata   <= data;
      axil_req.wstrb   <= 4'hf;
      @(negedge clk);
      while (!axil_rsp.awready) @(negedge clk);
      compare("wready", 32'd1, 32'(axil_rsp.wready));   // Both channels taken together
      @(posedge clk);                       // Accept edge
      axil_req.awvalid <= 1'b0;
      axil_req.wvalid  <= 1'b0;
      axil_req.bready  <= 1'b1;
      @(negedge clk);
      while (!axil_rsp.bvalid) @(negedge clk);
      resp = axil_rsp.bresp;
      @(posedge clk);
      axil_req.bready  <= 1'b0;
   endtask

   task automatic axi_read(input logic [11:0] addr, input int stall,
                           output logic [31:0] data, output logic [1:0] resp);
      logic [31:0] held;
      @(posedge clk);
      axil_req.arvalid <= 1'b1;
      axil_req.araddr  <= addr;
      axil_req.rready  <= 1'b0;
      @(negedge clk);
      while (!axil_rsp.arready) @(negedge clk);
      @(posedge clk);
      axil_req.arvalid <= 1'b0;
      axil_req.araddr  <= addr ^ 12'h004;   // Address may move once the beat is accepted
      @(negedge clk);                       // Beat is up, master still stalling
      held = axil_rsp.rdata;
      compare("rvalid", 32'd1, 32'(axil_rsp.rvalid));
      repeat (stall) begin
         @(negedge clk);
         compare("rvalid", 32'd1, 32'(axil_rsp.rvalid));
         compare("rdata held", held, axil_rsp.rdata);
      end
      @(posedge clk);
      axil_req.rready  <= 1'b1;
      @(negedge clk);
      data = axil_rsp.rdata;
      resp = axil_rsp.rresp;
      @(posedge clk);                       // Beat taken here
      axil_req.rready  <= 1'b0;
   endtask

   task automatic write_check(input logic [11:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
      logic [1:0] resp;
      axi_write(addr, data, resp);
      compare("bresp", 32'(exp_resp), 32'(resp));
   endtask

   task automatic read_check(input string name, input logic [11:0] addr, input int stall,
                             input logic [31:0] exp, input logic [1:0] exp_resp);
      logic [31:0] data;
      logic [1:0]  resp;
      axi_read(addr, stall, data, resp);
      compare({name, " rresp"}, 32'(exp_resp), 32'(resp));
      compare(name, exp, data);
   endtask

   //------------------------------------------------------------
   // Reference model and stimulus
   //------------------------------------------------------------
   task automatic model_sample(input logic [N_ANT-1:0] s);
      int ia, ib;
      if (m_en) begin
         for (int p = 0; p < N_PAIR; p++) begin
            ia = int'(corr_cfg_pkg::PAIR_A[p]);
            ib = int'(corr_cfg_pkg::PAIR_B[p]);
            if (s[ia] == s[ib])      m_acc[p]        = m_acc[p] + 32'd1;        // Cosine
            if (s[ia] == m_prev[ib]) m_acc[N_PAIR+p] = m_acc[N_PAIR+p] + 32'd1; // Sine
         end
         for (int k = 0; k < N_ANT; k++) begin
            if (s[k]) m_acc[2*N_PAIR+k] = m_acc[2*N_PAIR+k] + 32'd1;          // Ones
         end
         m_prev = s;
         if (m_cnt == m_len) begin                // Block end, publish and restart
            for (int k = 0; k < N_VIS; k++) begin
               m_bank[k] = m_acc[k];
               m_acc[k]  = '0;
            end
            m_cnt = 0;
            m_status++;
         end else begin
            m_cnt++;
         end
      end
   endtask

   task automatic drive_samples(input int n);
      logic [31:0] r;
      for (int i = 0; i < n; i++) begin
         draw(2, r);
         repeat (int'(r[1:0])) begin      // Random gap before the strobe
            @(posedge clk);
            sample_valid <= 1'b0;
         end
         draw(N_ANT, r);
         @(posedge clk);
         sample_valid <= 1'b1;
         sample       <= r[N_ANT-1:0];
         model_sample(r[N_ANT-1:0]);
      end
      @(posedge clk);
      sample_valid <= 1'b0;
   endtask

   task automatic set_enable(input logic en);
      write_check(axil_pkg::ADDR_CTRL, {31'b0, en}, axil_pkg::RESP_OKAY);
      m_en = en;
      if (!en) begin
         m_cnt  = 0;                         // Counter and history restart
         m_prev = '0;
      end
   endtask

   task automatic set_len(input int len);
      write_check(axil_pkg::ADDR_BLKSIZE, 32'(len - 1), axil_pkg::RESP_OKAY);
      m_len = len - 1;
   endtask

   task automatic wait_status();
      logic [31:0] d;
      logic [1:0]  r;
      for (int i = 0; i < 20; i++) begin
         axi_read(axil_pkg::ADDR_STATUS, 0, d, r);
         compare("STATUS rresp", 32'(axil_pkg::RESP_OKAY), 32'(r));
         if (d == 32'(m_status)) break;
      end
      compare("STATUS", 32'(m_status), d);
   endtask

   task automatic check_words(input logic rand_stall);
      logic [31:0] r;
      int          stall;
      for (int k = 0; k < N_VIS; k++) begin
         stall = 0;
         if (rand_stall) begin
            draw(3, r);
            stall = 2 + int'(r[2:0]);
         end
         read_check($sformatf("vis[%0d]", k), axil_pkg::ADDR_VIS_BASE + 12'(4*k), stall,
                    m_bank[k], axil_pkg::RESP_OKAY);
      end
   endtask

   //------------------------------------------------------------
   // Test sequence
   //------------------------------------------------------------
   initial begin
      logic [31:0] r;
      int          e0;
      lfsr         = 32'h3f74;
      sw_d         = 1'b1;
      sample_valid = 1'b0;
      sample       = '0;
      axil_req     = '0;
      m_en         = 1'b0;
      m_cnt        = 0;
      m_len        = 0;
      m_status     = 0;
      m_prev       = '0;
      for (int k = 0; k < N_VIS; k++) begin
         m_acc[k]  = '0;
         m_bank[k] = '0;
      end
      repeat (5) @(posedge clk);
      sw_d <= 1'b0;

      e0 = n_errors;                         // Reset state
      read_check("CTRL", axil_pkg::ADDR_CTRL, 0, 32'd0, axil_pkg::RESP_OKAY);
      read_check("BLKSIZE", axil_pkg::ADDR_BLKSIZE, 0, 32'd0, axil_pkg::RESP_OKAY);
      read_check("STATUS", axil_pkg::ADDR_STATUS, 0, 32'd0, axil_pkg::RESP_OKAY);
      check_words(1'b0);
      test_done("reset_state", e0);

      e0 = n_errors;                         // Register access
      set_enable(1'b1);
      read_check("CTRL", axil_pkg::ADDR_CTRL, 0, 32'd1, axil_pkg::RESP_OKAY);
      set_enable(1'b0);
      write_check(axil_pkg::ADDR_BLKSIZE, 32'h0000_1234, axil_pkg::RESP_OKAY);
      read_check("BLKSIZE", axil_pkg::ADDR_BLKSIZE, 0, 32'h1234, axil_pkg::RESP_OKAY);
      write_check(axil_pkg::ADDR_STATUS, 32'h5, axil_pkg::RESP_SLVERR);
      read_check("STATUS", axil_pkg::ADDR_STATUS, 0, 32'd0, axil_pkg::RESP_OKAY);
      read_check("unmapped", 12'h00c, 0, 32'd0, axil_pkg::RESP_SLVERR);
      read_check("past vis", 12'h140, 0, 32'd0, axil_pkg::RESP_SLVERR);
      test_done("register_access", e0);

      e0 = n_errors;                         // One block of 20
      set_len(20);
      set_enable(1'b1);
      drive_samples(20);
      wait_status();
      check_words(1'b0);
      test_done("one_block", e0);

      e0 = n_errors;                         // Three blocks of random length
      repeat (3) begin
         draw(5, r);
         set_len(8 + int'(r[4:0]));
         drive_samples(m_len + 1);
         wait_status();
         check_words(1'b0);
      end
      test_done("several_blocks", e0);

      e0 = n_errors;                         // Enable gating
      set_enable(1'b0);
      drive_samples(10);                     // Ignored by DUT and model
      wait_status();
      check_words(1'b0);
      set_len(16);
      set_enable(1'b1);
      drive_samples(7);                      // Partial block, sums stay in accumulators
      set_enable(1'b0);
      set_enable(1'b1);
      drive_samples(16);
      wait_status();
      check_words(1'b0);
      test_done("enable_gating", e0);

      e0 = n_errors;                         // Read back-pressure
      check_words(1'b1);
      test_done("read_backpressure", e0);

      $display("%0d checks run, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== corr_top.f ====
logic/corr_cfg_pkg.sv
logic/axil_pkg.sv
logic/sample_front.sv
logic/vis_accum.sv
logic/corr_bus_regs.sv
logic/corr_top.sv
testbench/tb_clock.sv
testbench/corr_top_tb.sv

// ==== Makefile ====
# Verilator flow for the correlator testbench

VERILATOR ?= verilator
TOP       ?= corr_top_tb
RTL_TOP   ?= corr_top
FILELIST  ?= corr_top.f
MDIR      ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

# Lint the design on its own top level
lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Build and run, the exit status follows the search for the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(MDIR)
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)
